// File: proc.f
rtl/proc_pkg.sv
rtl/proc_ctrl.sv
rtl/pc_counter.sv
rtl/instr_mem.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/proc.sv
tb/proc_assert.sv
tb/proc_tb.sv

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu (
   input  proc_pkg::dec_instr_t        dec,
   input  logic [proc_pkg::DATA_W-1:0] rs_data,
   input  logic [proc_pkg::DATA_W-1:0] rt_data,
   output logic [proc_pkg::DATA_W-1:0] result,
   output logic                        rs_zero
);
   import proc_pkg::*;

   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] alu_out;

   // Second operand from rt or the immediate
   assign op_b = dec.use_imm ? dec.imm : rt_data;

   always_comb begin
      case (dec.alu_op)
         ALU_ADD: alu_out = rs_data + op_b;
         // rs minus operand, no borrow out
         ALU_SUB: alu_out = rs_data - op_b;
         ALU_AND: alu_out = rs_data & op_b;
         ALU_XOR: alu_out = rs_data ^ op_b;
         default: alu_out = '0;
      endcase
   end

   // LBI bypasses the arithmetic
   assign result = dec.pass_imm ? dec.imm : alu_out;

   // Branch condition
   assign rs_zero = rs_data == '0;

endmodule

// File: rtl/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
   input  logic [proc_pkg::DATA_W-1:0] instr,
   output proc_pkg::dec_instr_t        dec
);
   import proc_pkg::*;

   opcode_e           opcode;
   logic [DATA_W-1:0] imm5_sx;
   logic [DATA_W-1:0] imm8_sx;

   assign opcode = opcode_e'(instr[15:11]);

   // Sign extension of both immediate sizes
   assign imm5_sx = {{(DATA_W-5){instr[4]}}, instr[4:0]};
   assign imm8_sx = {{(DATA_W-8){instr[7]}}, instr[7:0]};

   always_comb begin
      // R-type field layout by default
      dec           = '0;
      dec.alu_op    = ALU_ADD;
      dec.rs        = instr[10:8];
      dec.rt        = instr[7:5];
      dec.rd        = instr[4:2];
      case (opcode)
         OP_HALT: dec.is_halt = 1'b1;
         OP_NOP: begin
         end
         OP_ADDI, OP_XORI: begin
            // I-type, rd moves up to bits 7:5
            dec.rd      = instr[7:5];
            dec.imm     = imm5_sx;
            dec.use_imm = 1'b1;
            dec.reg_we  = 1'b1;
            dec.alu_op  = (opcode == OP_XORI) ? ALU_XOR : ALU_ADD;
         end
         OP_BEQZ: begin
            dec.imm       = imm8_sx;
            dec.is_branch = 1'b1;
         end
         OP_LBI: begin
            // rs field doubles as destination
            dec.rd       = instr[10:8];
            dec.imm      = imm8_sx;
            dec.pass_imm = 1'b1;
            dec.reg_we   = 1'b1;
         end
         OP_ADD: dec.reg_we = 1'b1;
         OP_SUB: begin
            dec.alu_op = ALU_SUB;
            dec.reg_we = 1'b1;
         end
         OP_AND: begin
            dec.alu_op = ALU_AND;
            dec.reg_we = 1'b1;
         end
         OP_XOR: begin
            dec.alu_op = ALU_XOR;
            dec.reg_we = 1'b1;
         end
         // Unused encodings stop the core
         default: dec.illegal = 1'b1;
      endcase
   end

endmodule

// File: rtl/instr_mem.sv
`timescale 1ns/10ps

module instr_mem (
   input  logic                         clk,
   input  logic [proc_pkg::DATA_W-1:0]  pc,
   input  logic                         we,
   input  logic [proc_pkg::IMEM_AW-1:0] waddr,
   input  logic [proc_pkg::DATA_W-1:0]  wdata,
   input  logic [proc_pkg::IMEM_AW-1:0] dbg_addr,
   output logic [proc_pkg::DATA_W-1:0]  instr,
   output logic [proc_pkg::DATA_W-1:0]  dbg_rdata
);
   import proc_pkg::*;

   logic [DATA_W-1:0] mem [2**IMEM_AW];

   // Loaded over APB only
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Byte-addressed pc, word-indexed store
   assign instr = mem[pc[IMEM_AW:1]];

   // Read-back port for the bus
   assign dbg_rdata = mem[dbg_addr];

endmodule

// File: rtl/pc_counter.sv
`timescale 1ns/10ps

module pc_counter (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        run_en,
   input  logic                        start_pulse,
   input  proc_pkg::dec_instr_t        dec,
   input  logic                        rs_zero,
   output logic [proc_pkg::DATA_W-1:0] pc,
   output logic [proc_pkg::DATA_W-1:0] retired
);
   import proc_pkg::*;

   logic              retire;
   logic              taken;
   logic [DATA_W-1:0] pc_inc;
   logic [DATA_W-1:0] pc_nxt;

   // HALT and illegal opcodes hold pc and are not counted
   assign retire = run_en & ~dec.is_halt & ~dec.illegal;

   // BEQZ taken when rs is zero, offset relative to pc + 2
   assign taken  = dec.is_branch & rs_zero;
   assign pc_inc = pc + DATA_W'(2);
   assign pc_nxt = taken ? pc_inc + dec.imm : pc_inc;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc      <= '0;
         retired <= '0;
      end else if (start_pulse) begin
         pc      <= '0;
         retired <= '0;
      end else if (retire) begin
         pc      <= pc_nxt;
         retired <= retired + DATA_W'(1);
      end
   end

endmodule

// File: rtl/proc.sv
`timescale 1ns/10ps

module proc (
   input  logic               clk,
   input  logic               arst_n,
   input  proc_pkg::apb_req_t apb_req,
   output proc_pkg::apb_rsp_t apb_rsp,
   output logic               err
);
   import proc_pkg::*;

   logic [DATA_W-1:0]    pc;
   logic [DATA_W-1:0]    retired;
   logic [DATA_W-1:0]    instr;
   logic [DATA_W-1:0]    imem_rdata;
   logic                 imem_we;
   logic [IMEM_AW-1:0]   imem_addr;
   logic [DATA_W-1:0]    imem_wdata;
   logic                 run_en;
   logic                 start_pulse;
   logic [REG_SEL_W-1:0] dbg_reg_sel;
   logic [DATA_W-1:0]    reg_rdata;
   dec_instr_t           dec;
   logic [DATA_W-1:0]    rs_data;
   logic [DATA_W-1:0]    rt_data;
   logic [DATA_W-1:0]    result;
   logic                 rs_zero;
   logic                 rf_we;

   // Run control and APB slave
   proc_ctrl i_proc_ctrl (
      .clk(clk), .arst_n(arst_n), .apb_req(apb_req), .dec(dec),
      .imem_rdata(imem_rdata), .reg_rdata(reg_rdata), .retired(retired),
      .apb_rsp(apb_rsp), .run_en(run_en), .start_pulse(start_pulse),
      .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
      .dbg_reg_sel(dbg_reg_sel), .err(err)
   );

   // Fetch
   pc_counter i_pc_counter (
      .clk(clk), .arst_n(arst_n), .run_en(run_en), .start_pulse(start_pulse),
      .dec(dec), .rs_zero(rs_zero), .pc(pc), .retired(retired)
   );

   instr_mem i_instr_mem (
      .clk(clk), .pc(pc), .we(imem_we), .waddr(imem_addr), .wdata(imem_wdata),
      .dbg_addr(imem_addr), .instr(instr), .dbg_rdata(imem_rdata)
   );

   // Decode
   instr_decode i_instr_decode (.instr(instr), .dec(dec));

   // Writes only retire while running
   assign rf_we = run_en & dec.reg_we;

   reg_file i_reg_file (
      .clk(clk), .arst_n(arst_n), .rs(dec.rs), .rt(dec.rt), .we(rf_we),
      .wsel(dec.rd), .wdata(result), .dbg_sel(dbg_reg_sel),
      .rs_data(rs_data), .rt_data(rt_data), .dbg_data(reg_rdata)
   );

   // Execute
   alu i_alu (
      .dec(dec), .rs_data(rs_data), .rt_data(rt_data),
      .result(result), .rs_zero(rs_zero)
   );

endmodule

// File: rtl/proc_ctrl.sv
`timescale 1ns/10ps

module proc_ctrl (
   input  logic                           clk,
   input  logic                           arst_n,
   input  proc_pkg::apb_req_t             apb_req,
   input  proc_pkg::dec_instr_t           dec,
   input  logic [proc_pkg::DATA_W-1:0]    imem_rdata,
   input  logic [proc_pkg::DATA_W-1:0]    reg_rdata,
   input  logic [proc_pkg::DATA_W-1:0]    retired,
   output proc_pkg::apb_rsp_t             apb_rsp,
   output logic                           run_en,
   output logic                           start_pulse,
   output logic                           imem_we,
   output logic [proc_pkg::IMEM_AW-1:0]   imem_addr,
   output logic [proc_pkg::DATA_W-1:0]    imem_wdata,
   output logic [proc_pkg::REG_SEL_W-1:0] dbg_reg_sel,
   output logic                           err
);
   import proc_pkg::*;

   ctrl_state_e        state;
   ctrl_state_e        state_nxt;
   logic               access;
   logic               wr_access;
   logic               is_mem;
   logic               is_ctrl;
   logic               is_status;
   logic               is_retired;
   logic               is_reg;
   logic               stop_cmd;
   logic               ro_write;
   logic [PADDR_W-1:0] reg_off;
   logic [DATA_W-1:0]  status_word;

   // Access phase of an APB transfer, no wait states
   assign access    = apb_req.psel & apb_req.penable;
   assign wr_access = access & apb_req.pwrite;

   // Address decode
   assign reg_off    = apb_req.paddr - REG_BASE;
   assign is_mem     = apb_req.paddr < CTRL_ADDR;
   assign is_ctrl    = apb_req.paddr == CTRL_ADDR;
   assign is_status  = apb_req.paddr == STATUS_ADDR;
   assign is_retired = apb_req.paddr == RETIRED_ADDR;
   assign is_reg     = (apb_req.paddr >= REG_BASE) && (reg_off < (PADDR_W'(4) << REG_SEL_W));

   // Word index for memory, register index for the debug window
   assign imem_addr   = apb_req.paddr[IMEM_AW:1];
   assign imem_wdata  = apb_req.pwdata;
   assign dbg_reg_sel = reg_off[REG_SEL_W+1:2];

   // Program load only allowed while stopped
   assign imem_we = wr_access & is_mem & (state != ST_RUN);

   // Control register commands
   assign start_pulse = wr_access & is_ctrl & apb_req.pwdata[0] & (state != ST_RUN);
   assign stop_cmd    = wr_access & is_ctrl & apb_req.pwdata[1];

   assign run_en = state == ST_RUN;

   // Illegal writes: memory while running, or any read-only location
   assign ro_write = (is_mem & (state == ST_RUN)) | is_status | is_retired | is_reg;

   assign status_word = {{(DATA_W-3){1'b0}}, err, state == ST_HALTED, state == ST_RUN};

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE, ST_HALTED: begin
            if (start_pulse) begin
               state_nxt = ST_RUN;
            end
         end
         ST_RUN: begin
            // Stop from APB, or the core hits HALT / bad opcode
            if (stop_cmd || dec.is_halt || dec.illegal) begin
               state_nxt = ST_HALTED;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         err   <= 1'b0;
      end else begin
         state <= state_nxt;
         // Sticky until the next start
         if (start_pulse) begin
            err <= 1'b0;
         end else if (run_en && dec.illegal) begin
            err <= 1'b1;
         end
      end
   end

   // Read data mux, purely on address
   always_comb begin
      apb_rsp.prdata = '0;
      if (is_mem) begin
         apb_rsp.prdata = imem_rdata;
      end else if (is_status) begin
         apb_rsp.prdata = status_word;
      end else if (is_retired) begin
         apb_rsp.prdata = retired;
      end else if (is_reg) begin
         apb_rsp.prdata = reg_rdata;
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = wr_access & ro_write;

endmodule

// File: rtl/proc_pkg.sv
package proc_pkg;

   // Datapath and address widths
   localparam int DATA_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int IMEM_AW   = 7;
   localparam int PADDR_W   = 12;

   // APB register map, instruction memory sits below CTRL_ADDR
   localparam logic [PADDR_W-1:0] CTRL_ADDR    = 12'h800;
   localparam logic [PADDR_W-1:0] STATUS_ADDR  = 12'h804;
   localparam logic [PADDR_W-1:0] RETIRED_ADDR = 12'h808;
   localparam logic [PADDR_W-1:0] REG_BASE     = 12'h810;

   // Major opcode in instr[15:11]
   typedef enum logic [4:0] {
      OP_HALT = 5'd0,
      OP_NOP  = 5'd1,
      OP_ADDI = 5'd8,
      OP_XORI = 5'd10,
      OP_BEQZ = 5'd12,
      OP_LBI  = 5'd24,
      OP_ADD  = 5'd27,
      OP_SUB  = 5'd28,
      OP_AND  = 5'd29,
      OP_XOR  = 5'd30
   } opcode_e;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_e;

   typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HALTED} ctrl_state_e;

   typedef struct packed {
      logic               psel;
      logic               penable;
      logic               pwrite;
      logic [PADDR_W-1:0] paddr;
      logic [DATA_W-1:0]  pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   // Fully decoded instruction, imm already sign-extended
   typedef struct packed {
      alu_op_e              alu_op;
      logic [REG_SEL_W-1:0] rs;
      logic [REG_SEL_W-1:0] rt;
      logic [REG_SEL_W-1:0] rd;
      logic [DATA_W-1:0]    imm;
      logic                 use_imm;
      logic                 pass_imm;
      logic                 reg_we;
      logic                 is_branch;
      logic                 is_halt;
      logic                 illegal;
   } dec_instr_t;

endpackage

// File: rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [proc_pkg::REG_SEL_W-1:0] rs,
   input  logic [proc_pkg::REG_SEL_W-1:0] rt,
   input  logic                           we,
   input  logic [proc_pkg::REG_SEL_W-1:0] wsel,
   input  logic [proc_pkg::DATA_W-1:0]    wdata,
   input  logic [proc_pkg::REG_SEL_W-1:0] dbg_sel,
   output logic [proc_pkg::DATA_W-1:0]    rs_data,
   output logic [proc_pkg::DATA_W-1:0]    rt_data,
   output logic [proc_pkg::DATA_W-1:0]    dbg_data
);
   import proc_pkg::*;

   logic [DATA_W-1:0] regs [2**REG_SEL_W];

   // Single write port, new value visible the cycle after
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**REG_SEL_W; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wsel] <= wdata;
      end
   end

   // Execution operands
   assign rs_data = regs[rs];
   assign rt_data = regs[rt];

   // APB register window
   assign dbg_data = regs[dbg_sel];

endmodule

// File: tb/proc_assert.sv
`timescale 1ns/10ps

module proc_assert (
   input logic                  clk,
   input logic                  arst_n,
   input proc_pkg::ctrl_state_e state,
   input proc_pkg::apb_req_t    apb_req,
   input proc_pkg::apb_rsp_t    apb_rsp,
   input logic                  run_en,
   input logic                  start_pulse,
   input logic                  imem_we,
   input logic                  err
);
   import proc_pkg::*;

   // Number of assertion failures so far
   int fail_count = 0;

   // Slave error only in the access phase, and a rejected write never lands in memory
   a_slverr_access: assert property (@(posedge clk) disable iff (!arst_n)
      apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable && !imem_we))
      else begin
         fail_count++;
         $error("pslverr raised outside an access phase or with a memory write");
      end

   // Sticky err is cleared on start and set only when leaving ST_RUN
   a_no_err_in_run: assert property (@(posedge clk) disable iff (!arst_n)
      (state == ST_RUN) |-> !err)
      else begin
         fail_count++;
         $error("err is high while the core is running");
      end

   // run_en rises one cycle after a start command and never otherwise
   a_run_en_state: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(run_en) == $past(start_pulse))
      else begin
         fail_count++;
         $error("run_en did not follow the start command");
      end

endmodule

bind proc_ctrl proc_assert i_proc_assert (
   .clk(clk), .arst_n(arst_n), .state(state), .apb_req(apb_req),
   .apb_rsp(apb_rsp), .run_en(run_en), .start_pulse(start_pulse),
   .imem_we(imem_we), .err(err)
);

// File: tb/proc_tb.sv
`timescale 1ns/10ps

module proc_tb;
   import proc_pkg::*;

   localparam int N_ROWS = 12;
   localparam logic [DATA_W-1:0] HALT_WORD = 16'h0000;

   // One ALU test: operation, operands, expected r3
   typedef struct packed {
      opcode_e           op;
      logic [7:0]        a;
      logic [7:0]        b;
      logic [DATA_W-1:0] exp;
   } alu_row_t;

   logic              clk;
   logic              arst_n;
   apb_req_t          apb_req;
   apb_rsp_t          apb_rsp;
   logic              err;
   alu_row_t          rows [N_ROWS];
   logic [DATA_W-1:0] prog [$];
   logic [31:0]       rnd_state;
   opcode_e           ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_XORI};

   proc i_proc (.clk(clk), .arst_n(arst_n), .apb_req(apb_req), .apb_rsp(apb_rsp), .err(err));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Expected result from the ISA rules, imm5 for the I-type forms
   function automatic logic [DATA_W-1:0] alu_model(opcode_e op, logic [7:0] a, logic [7:0] b);
      logic [DATA_W-1:0] x;
      logic [DATA_W-1:0] y;
      x = {{8{a[7]}}, a};
      if (op == OP_ADDI || op == OP_XORI) begin
         y = {{11{b[4]}}, b[4:0]};
      end else begin
         y = {{8{b[7]}}, b};
      end
      case (op)
         OP_SUB: return x - y;
         OP_AND: return x & y;
         OP_XOR, OP_XORI: return x ^ y;
         default: return x + y;
      endcase
   endfunction

   // Instruction encoders
   function automatic logic [DATA_W-1:0] enc_lbi(logic [2:0] rd, logic [7:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic logic [DATA_W-1:0] enc_beqz(logic [2:0] rs, logic [7:0] off);
      return {OP_BEQZ, rs, off};
   endfunction

   function automatic logic [DATA_W-1:0] enc_r(opcode_e op, logic [2:0] rs, logic [2:0] rt,
                                               logic [2:0] rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic logic [DATA_W-1:0] enc_i(opcode_e op, logic [2:0] rs, logic [2:0] rd,
                                               logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [PADDR_W-1:0] reg_addr(int n);
      return REG_BASE + PADDR_W'(4 * n);
   endfunction

   task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // Setup, access, then back to idle; response sampled mid access cycle
   task automatic apb_xfer(input logic wr, input logic [PADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                           output logic slverr);
      apb_req_t req;
      req = '0;
      req.psel = 1'b1;
      req.pwrite = wr;
      req.paddr = addr;
      req.pwdata = wdata;
      @(posedge clk);
      apb_req <= req;
      req.penable = 1'b1;
      @(posedge clk);
      apb_req <= req;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      // No wait states on this slave
      check_val("pready", apb_rsp.pready, 1'b1);
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic write_expect(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic exp_slverr);
      logic [DATA_W-1:0] rdata;
      logic              slverr;
      apb_xfer(1'b1, addr, data, rdata, slverr);
      check_val("pslverr", slverr, exp_slverr);
   endtask

   task automatic read_check(input string name, input logic [PADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rdata;
      logic              slverr;
      apb_xfer(1'b0, addr, '0, rdata, slverr);
      check_val("pslverr", slverr, 1'b0);
      check_val(name, rdata, exp);
   endtask

   // Write the queued program, then read every word back
   task automatic load_program();
      foreach (prog[i]) begin
         write_expect(PADDR_W'(2 * i), prog[i], 1'b0);
      end
      foreach (prog[i]) begin
         read_check("imem", PADDR_W'(2 * i), prog[i]);
      end
   endtask

   task automatic wait_halted(output logic [DATA_W-1:0] status);
      logic slverr;
      status = '0;
      while (!status[1]) begin
         apb_xfer(1'b0, STATUS_ADDR, '0, status, slverr);
      end
   endtask

   task automatic run_program(input logic [DATA_W-1:0] exp_status);
      logic [DATA_W-1:0] status;
      write_expect(CTRL_ADDR, 16'h0001, 1'b0);
      wait_halted(status);
      check_val("status", status, exp_status);
   endtask

   task automatic check_err_port(input logic exp);
      @(negedge clk);
      check_val("err", err, exp);
   endtask

   // Watchdog sized from the table length
   initial begin
      repeat (N_ROWS * 40 + 400) @(posedge clk);
      $display("Watchdog timeout, the tests did not finish in time");
      $display("Simulation failed");
      $fatal(1);
   end

   // Stop at the first failing concurrent assertion
   initial begin
      wait (i_proc.i_proc_ctrl.i_proc_assert.fail_count != 0);
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      logic [DATA_W-1:0] status;
      apb_req = '0;
      arst_n = 1'b0;
      rnd_state = 32'd4;
      // Build the ALU table
      for (int i = 0; i < N_ROWS; i++) begin
         rnd_state = xorshift(rnd_state);
         rows[i].op = ops[i % 6];
         rows[i].a = rnd_state[7:0];
         rows[i].b = rnd_state[15:8];
         rows[i].exp = alu_model(rows[i].op, rows[i].a, rows[i].b);
      end
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      // State after reset
      read_check("status", STATUS_ADDR, 16'h0000);
      read_check("retired", RETIRED_ADDR, 16'h0000);
      check_err_port(1'b0);
      for (int r = 0; r < 8; r++) begin
         read_check($sformatf("r%0d", r), reg_addr(r), 16'h0000);
      end

      // ALU table, result always lands in r3
      for (int i = 0; i < N_ROWS; i++) begin
         prog.delete();
         prog.push_back(enc_lbi(3'd1, rows[i].a));
         prog.push_back(enc_lbi(3'd2, rows[i].b));
         if (rows[i].op == OP_ADDI || rows[i].op == OP_XORI) begin
            prog.push_back(enc_i(rows[i].op, 3'd1, 3'd3, rows[i].b[4:0]));
         end else begin
            prog.push_back(enc_r(rows[i].op, 3'd1, 3'd2, 3'd3));
         end
         prog.push_back(HALT_WORD);
         load_program();
         run_program(16'h0002);
         read_check("r3", reg_addr(3), rows[i].exp);
         read_check("retired", RETIRED_ADDR, 16'd3);
      end

      // Clear r1..r7 so the branch results start from zero
      prog.delete();
      for (int r = 1; r < 8; r++) begin
         prog.push_back(enc_lbi(3'(r), 8'h00));
      end
      prog.push_back(HALT_WORD);
      load_program();
      run_program(16'h0002);

      // Taken branch skips LBI r2
      prog.delete();
      prog.push_back(enc_lbi(3'd1, 8'h00));
      prog.push_back(enc_beqz(3'd1, 8'h02));
      prog.push_back(enc_lbi(3'd2, 8'h05));
      prog.push_back(enc_lbi(3'd4, 8'h07));
      prog.push_back(HALT_WORD);
      load_program();
      run_program(16'h0002);
      read_check("r2", reg_addr(2), 16'h0000);
      read_check("r4", reg_addr(4), 16'h0007);
      read_check("retired", RETIRED_ADDR, 16'd3);

      // Not taken with r1 = 1
      prog[0] = enc_lbi(3'd1, 8'h01);
      load_program();
      run_program(16'h0002);
      read_check("r2", reg_addr(2), 16'h0005);
      read_check("retired", RETIRED_ADDR, 16'd4);

      // Opcode 2 is unused
      prog.delete();
      prog.push_back({OP_NOP, 11'd0});
      prog.push_back(16'h1000);
      prog.push_back(HALT_WORD);
      load_program();
      run_program(16'h0006);
      check_err_port(1'b1);
      read_check("retired", RETIRED_ADDR, 16'd1);
      // Patch the bad word, restart must clear err
      write_expect(12'h002, HALT_WORD, 1'b0);
      run_program(16'h0002);
      check_err_port(1'b0);
      read_check("retired", RETIRED_ADDR, 16'd1);

      // Self loop on r0, bus writes while running
      prog.delete();
      prog.push_back(enc_beqz(3'd0, 8'hFE));
      load_program();
      write_expect(CTRL_ADDR, 16'h0001, 1'b0);
      read_check("status", STATUS_ADDR, 16'h0001);
      write_expect(12'h000, 16'hFFFF, 1'b1);
      read_check("imem", 12'h000, prog[0]);
      write_expect(STATUS_ADDR, 16'h0001, 1'b1);
      write_expect(CTRL_ADDR, 16'h0002, 1'b0);
      wait_halted(status);
      check_val("status", status, 16'h0002);
      check_err_port(1'b0);

      if (i_proc.i_proc_ctrl.i_proc_assert.fail_count == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1);
      end
   end

endmodule
